//--- fetch_pkg.sv
// fetch package with the shared widths, buffer geometry and fetch FSM states
package fetch_pkg;

   // one cache line, four of them in the ring
   localparam int LINE_BYTES = 16;
   localparam int NUM_SLOTS  = 4;
   localparam int LINE_BITS  = LINE_BYTES * 8;
   localparam int BUF_BYTES  = LINE_BYTES * NUM_SLOTS;

   // segment base lands 16 bits up in the linear address
   localparam int SEG_SHIFT  = 16;

   // linear or EIP address
   typedef logic [31:0] addr_t;

   // code segment value
   typedef logic [15:0] seg_t;

   // one cache line or one instruction window, byte 0 at the top
   typedef logic [LINE_BITS-1:0] line_t;

   // index of a buffer line
   typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;

   // byte offset into the 64-byte ring
   typedef logic [$clog2(BUF_BYTES)-1:0] byte_ptr_t;

   // instruction length from the decoder, 1 to 15
   typedef logic [3:0] len_t;

   // buffered byte count, 0 to 64 inclusive
   typedef logic [$clog2(BUF_BYTES):0] fill_cnt_t;

   // fetch controller states
   typedef enum logic [1:0] {
      st_reset,
      st_flush,
      st_fill,
      st_full
   } fetch_state_t;

endpackage

//--- fetch_line_if.sv
// line interface between the cache fill path, the fetch controller and the line store
interface fetch_line_if import fetch_pkg::*; ();

   // line hand-off from the cache side
   logic      wr_en;
   line_t     wr_data;

   // slot and read position kept by the controller
   slot_t     wr_slot;
   byte_ptr_t rd_ptr;

   // aligned window back out of the store
   line_t     window;

   modport fill (
      output wr_en,
      output wr_data
   );

   modport ctrl (
      input  wr_en,
      output wr_slot,
      output rd_ptr
   );

   modport store (
      input  wr_en,
      input  wr_slot,
      input  wr_data,
      input  rd_ptr,
      output window
   );

endinterface

//--- fetch_ctrl.sv
// fetch controller FSM tracking buffer occupancy, slot and read pointers and the EIP
module fetch_ctrl import fetch_pkg::*; (
   input  logic  CLK,
   input  logic  rst,
   input  logic  flush,
   input  logic  dep_stall,
   input  len_t  instr_len,
   input  addr_t eip,

   fetch_line_if.ctrl line,

   output logic  start,
   output logic  may_request,
   output logic  ir_valid,
   output addr_t eip_out,
   output logic  fetch_stall
);

   fetch_state_t state;
   fetch_state_t state_next;
   fill_cnt_t    count;
   fill_cnt_t    count_next;
   slot_t        wr_slot;
   byte_ptr_t    rd_ptr;
   addr_t        eip_reg;
   logic         consume;
   logic         clear;

   // a full window is buffered
   assign ir_valid    = count >= fill_cnt_t'(LINE_BYTES);
   assign fetch_stall = !ir_valid;

   // decoder takes an instruction, unless the pipe is being redirected
   assign consume = ir_valid && !dep_stall && !flush;

   // drop everything buffered on flush and while restarting
   assign clear = flush || (state == st_flush) || (state == st_reset);

   // restart pulse for the fetch pointer
   assign start = (state == st_flush);

   // room for one more line
   assign may_request = !flush && ((state == st_flush) || (state == st_fill));

   assign line.wr_slot = wr_slot;
   assign line.rd_ptr  = rd_ptr;
   assign eip_out      = eip_reg;

   // occupancy after this cycle's write and consume
   always_comb begin
      count_next = count;
      if (clear) begin
         count_next = '0;
      end else begin
         if (line.wr_en) begin
            count_next = count_next + fill_cnt_t'(LINE_BYTES);
         end
         if (consume) begin
            count_next = count_next - fill_cnt_t'(instr_len);
         end
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         st_reset: begin
            state_next = st_flush;
         end
         st_flush: begin
            state_next = st_fill;
         end
         st_fill: begin
            // last free line just got taken
            if (count_next > fill_cnt_t'(BUF_BYTES - LINE_BYTES)) begin
               state_next = st_full;
            end
         end
         st_full: begin
            // wait until a whole line is consumed
            if (count_next <= fill_cnt_t'(BUF_BYTES - LINE_BYTES)) begin
               state_next = st_fill;
            end
         end
         default: begin
            state_next = st_reset;
         end
      endcase
      if (flush) begin
         state_next = st_flush;
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         state   <= st_reset;
         count   <= '0;
         wr_slot <= '0;
         rd_ptr  <= '0;
      end else begin
         state <= state_next;
         count <= count_next;
         if (clear) begin
            wr_slot <= '0;
            rd_ptr  <= '0;
         end else begin
            if (line.wr_en) begin
               wr_slot <= wr_slot + slot_t'(1);
            end
            // ring pointer wraps at 64
            if (consume) begin
               rd_ptr <= rd_ptr + byte_ptr_t'(instr_len);
            end
         end
      end
   end

   // EIP follows the consumed instructions
   always_ff @(posedge CLK) begin
      if (state == st_flush) begin
         eip_reg <= eip;
      end else if (consume) begin
         eip_reg <= eip_reg + addr_t'(instr_len);
      end
   end

   // requester must never deliver a line without room for it
   a_count_max: assert property (@(posedge CLK) disable iff (rst)
      count <= fill_cnt_t'(BUF_BYTES));

   a_no_valid_in_flush: assert property (@(posedge CLK) disable iff (rst)
      (state == st_flush) |-> !ir_valid);

endmodule

//--- icache_req.sv
// instruction cache requester holding the fetch pointer and one outstanding line request
module icache_req import fetch_pkg::*; (
   input  logic  CLK,
   input  logic  rst,
   input  logic  start,
   input  logic  may_request,

   fetch_line_if.fill line,

   input  logic  icache_ready,
   input  line_t icache_data,
   input  addr_t eip,
   input  seg_t  cs,
   output addr_t icache_addr,
   output logic  icache_en
);

   addr_t fetch_ptr;
   addr_t linear_addr;
   logic  pending;

   // segment base plus offset
   assign linear_addr = eip + (addr_t'(cs) << SEG_SHIFT);

   // request is dropped at once when the controller withdraws room
   assign icache_en   = pending && may_request;
   assign icache_addr = fetch_ptr;

   // line is handed over in the ready cycle itself
   assign line.wr_en   = icache_en && icache_ready;
   assign line.wr_data = icache_data;

   // next request waits a cycle after ready so the count sees the new line
   always_ff @(posedge CLK) begin
      if (rst) begin
         pending <= 1'b0;
      end else begin
         pending <= may_request && !line.wr_en;
      end
   end

   always_ff @(posedge CLK) begin
      if (start) begin
         fetch_ptr <= linear_addr;
      end else if (line.wr_en) begin
         fetch_ptr <= fetch_ptr + addr_t'(LINE_BYTES);
      end
   end

   // cache sees a steady address for the whole request
   a_addr_stable: assert property (@(posedge CLK) disable iff (rst)
      (icache_en && !icache_ready) |=> $stable(icache_addr));

endmodule

//--- line_buffer.sv
// line store with four 16-byte lines and the byte aligner that forms the instruction window
module line_buffer import fetch_pkg::*; (
   input logic CLK,
   input logic rst,

   fetch_line_if.store line
);

   line_t                   slot_q [NUM_SLOTS];
   logic [NUM_SLOTS-1:0]    slot_valid;
   slot_t                   hi_slot;
   slot_t                   lo_slot;
   line_t                   hi_line;
   line_t                   lo_line;
   logic [2*LINE_BITS-1:0]  pair;
   logic [2*LINE_BITS-1:0]  shifted;
   logic [6:0]              shift_bits;

   // line storage, written straight from the cache
   always_ff @(posedge CLK) begin
      if (line.wr_en) begin
         slot_q[line.wr_slot] <= line.wr_data;
      end
   end

   // slots not yet filled since reset read as zero
   always_ff @(posedge CLK) begin
      if (rst) begin
         slot_valid <= '0;
      end else if (line.wr_en) begin
         slot_valid[line.wr_slot] <= 1'b1;
      end
   end

   // line holding the current byte and the one after it
   assign hi_slot = line.rd_ptr[5:4];
   assign lo_slot = hi_slot + slot_t'(1);

   assign hi_line = slot_valid[hi_slot] ? slot_q[hi_slot] : '0;
   assign lo_line = slot_valid[lo_slot] ? slot_q[lo_slot] : '0;

   // byte offset within the line, in bits
   assign shift_bits = {line.rd_ptr[3:0], 3'b000};

   // byte 0 of each line sits in its top byte
   assign pair    = {hi_line, lo_line};
   assign shifted = pair << shift_bits;

   // first instruction byte ends up at 127:120
   assign line.window = shifted[2*LINE_BITS-1 -: LINE_BITS];

endmodule

//--- fetch_top.sv
// instruction fetch front end top, joining controller, cache requester and line store
module fetch_top import fetch_pkg::*; (
   input  logic  CLK,
   input  logic  rst,

   // architectural state from the pipeline
   input  addr_t eip,
   input  seg_t  cs,
   input  logic  flush,

   // decoder side
   input  logic  dep_stall,
   input  len_t  instr_len,

   // instruction cache
   input  line_t icache_data,
   input  logic  icache_ready,
   output addr_t icache_addr,
   output logic  icache_en,

   // instruction window out
   output line_t ir,
   output logic  ir_valid,
   output addr_t eip_out,
   output logic  fetch_stall
);

   logic start;
   logic may_request;

   fetch_line_if line ();

   fetch_ctrl u_ctrl (
      .CLK         (CLK),
      .rst         (rst),
      .flush       (flush),
      .dep_stall   (dep_stall),
      .instr_len   (instr_len),
      .eip         (eip),
      .line        (line.ctrl),
      .start       (start),
      .may_request (may_request),
      .ir_valid    (ir_valid),
      .eip_out     (eip_out),
      .fetch_stall (fetch_stall)
   );

   icache_req u_req (
      .CLK          (CLK),
      .rst          (rst),
      .start        (start),
      .may_request  (may_request),
      .line         (line.fill),
      .icache_ready (icache_ready),
      .icache_data  (icache_data),
      .eip          (eip),
      .cs           (cs),
      .icache_addr  (icache_addr),
      .icache_en    (icache_en)
   );

   line_buffer u_buf (
      .CLK  (CLK),
      .rst  (rst),
      .line (line.store)
   );

   // window goes straight to the decoder
   assign ir = line.window;

endmodule

//--- tb_icache_model.sv
// behavioral instruction cache with hashed line contents and a random latency of 1 to 4 cycles
module tb_icache_model import fetch_pkg::*; (
   input  logic  CLK,
   input  logic  rst,
   input  addr_t icache_addr,
   input  logic  icache_en,
   output line_t icache_data,
   output logic  icache_ready
);

   logic       busy;
   logic       ready_q;
   logic [1:0] wait_cnt;
   logic [1:0] lat;

   // memory contents derived from the byte address
   function automatic logic [7:0] hashed_byte(addr_t a);
      return a[7:0] ^ a[15:8];
   endfunction

   // byte 0 of the line in the top byte
   always_comb begin
      for (int k = 0; k < LINE_BYTES; k++) begin
         icache_data[LINE_BITS-1-8*k -: 8] = hashed_byte(icache_addr + addr_t'(k));
      end
   end

   // answer only while the request is still up
   assign icache_ready = ready_q && icache_en;

   always @(posedge CLK) begin
      if (rst || !icache_en) begin
         busy     <= 1'b0;
         ready_q  <= 1'b0;
         wait_cnt <= '0;
      end else if (ready_q) begin
         busy    <= 1'b0;
         ready_q <= 1'b0;
      end else if (!busy) begin
         // new request, pick its latency
         lat = 2'($urandom % 4);
         busy     <= 1'b1;
         wait_cnt <= lat;
         ready_q  <= (lat == 2'd0);
      end else if (wait_cnt != 2'd0) begin
         wait_cnt <= wait_cnt - 2'd1;
         ready_q  <= (wait_cnt == 2'd1);
      end
   end

endmodule

//--- tb_fetch.sv
// testbench for the fetch front end with a behavioral cache and assertion checks
module tb_fetch import fetch_pkg::*; ();

   localparam int CLK_PERIOD    = 8;
   localparam int RESET_CYCLES  = 10;
   localparam int T1_CYCLES     = 20;
   localparam int T2_CYCLES     = 200;
   localparam int T3_CYCLES     = 300;
   localparam int T4_CYCLES     = 350;
   localparam int T5_CYCLES     = 200;
   localparam int T6_CYCLES     = 400;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                  T4_CYCLES + T5_CYCLES + T6_CYCLES;
   localparam int WATCHDOG_TIME = TOTAL_CYCLES * 20 * CLK_PERIOD;
   localparam int RUN_LIMIT     = 400;

   logic  CLK = 1'b0;
   logic  rst;
   addr_t eip;
   seg_t  cs;
   logic  flush;
   logic  dep_stall;
   len_t  instr_len;
   line_t icache_data;
   logic  icache_ready;
   addr_t icache_addr;
   logic  icache_en;
   line_t ir;
   logic  ir_valid;
   addr_t eip_out;
   logic  fetch_stall;

   // reference state built from the bus activity
   addr_t next_addr;
   logic  first_req;
   addr_t prev_addr;
   addr_t exp_eip;
   int    held;

   // event counts showing which checks were reached
   int n_first = 0;
   int n_reqs = 0;
   int n_windows = 0;
   int n_consumes = 0;
   int n_stall_holds = 0;
   int n_full = 0;
   int n_flushes = 0;

   int check_errs = 0;
   int test_num = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   fetch_top DUT (
      .CLK          (CLK),
      .rst          (rst),
      .eip          (eip),
      .cs           (cs),
      .flush        (flush),
      .dep_stall    (dep_stall),
      .instr_len    (instr_len),
      .icache_data  (icache_data),
      .icache_ready (icache_ready),
      .icache_addr  (icache_addr),
      .icache_en    (icache_en),
      .ir           (ir),
      .ir_valid     (ir_valid),
      .eip_out      (eip_out),
      .fetch_stall  (fetch_stall)
   );

   tb_icache_model cache (
      .CLK          (CLK),
      .rst          (rst),
      .icache_addr  (icache_addr),
      .icache_en    (icache_en),
      .icache_data  (icache_data),
      .icache_ready (icache_ready)
   );

   // 16 bytes of memory from base with the first byte on top
   function automatic line_t expected_window(addr_t base);
      line_t w;
      addr_t a;
      for (int k = 0; k < LINE_BYTES; k++) begin
         a = base + addr_t'(k);
         w[LINE_BITS-1-8*k -: 8] = a[7:0] ^ a[15:8];
      end
      return w;
   endfunction

   task automatic report_mismatch(input string sig, input line_t got, input line_t exp);
      check_errs++;
      $display("Fail %s: got %0h expected %0h at time %0t", sig, got, exp, $time);
   endtask

   always @(posedge CLK) begin
      prev_addr <= icache_addr;
      if (rst || flush) begin
         // restart from the segment base plus eip
         next_addr <= eip + (addr_t'(cs) << SEG_SHIFT);
         exp_eip   <= eip;
         first_req <= 1'b1;
         held      <= 0;
         if (flush) begin
            n_flushes <= n_flushes + 1;
         end
      end else begin
         if (icache_en && icache_ready) begin
            next_addr <= next_addr + addr_t'(LINE_BYTES);
            first_req <= 1'b0;
            n_reqs    <= n_reqs + 1;
            if (first_req) begin
               n_first <= n_first + 1;
            end
         end
         held <= held + ((icache_en && icache_ready) ? LINE_BYTES : 0) -
                 ((ir_valid && !dep_stall) ? int'(instr_len) : 0);
         if (ir_valid) begin
            n_windows <= n_windows + 1;
         end
         if (ir_valid && !dep_stall) begin
            n_consumes <= n_consumes + 1;
            exp_eip    <= exp_eip + addr_t'(instr_len);
         end
         if (ir_valid && dep_stall) begin
            n_stall_holds <= n_stall_holds + 1;
         end
         if (held > BUF_BYTES - LINE_BYTES) begin
            n_full <= n_full + 1;
         end
      end
   end

   a_first_addr: assert property (@(posedge CLK) disable iff (rst)
      (icache_en && first_req) |-> icache_addr == next_addr)
      else report_mismatch("icache_addr", $sampled(icache_addr), $sampled(next_addr));

   a_next_addr: assert property (@(posedge CLK) disable iff (rst)
      (icache_en && !first_req) |-> icache_addr == next_addr)
      else report_mismatch("icache_addr", $sampled(icache_addr), $sampled(next_addr));

   // request held until ready unless redirected
   a_en_hold: assert property (@(posedge CLK) disable iff (rst)
      (icache_en && !icache_ready && !flush) |=> (flush || icache_en))
      else report_mismatch("icache_en", $sampled(icache_en), 1);

   a_addr_hold: assert property (@(posedge CLK) disable iff (rst)
      (icache_en && !icache_ready && !flush) |=> (flush || icache_addr == prev_addr))
      else report_mismatch("icache_addr", $sampled(icache_addr), $sampled(prev_addr));

   a_window: assert property (@(posedge CLK) disable iff (rst)
      (ir_valid && !flush) |-> ir == expected_window(exp_eip + (addr_t'(cs) << SEG_SHIFT)))
      else report_mismatch("ir", $sampled(ir),
                           expected_window($sampled(exp_eip) +
                                           (addr_t'($sampled(cs)) << SEG_SHIFT)));

   a_stall: assert property (@(posedge CLK) disable iff (rst)
      fetch_stall == !ir_valid)
      else report_mismatch("fetch_stall", $sampled(fetch_stall), !$sampled(ir_valid));

   a_eip_step: assert property (@(posedge CLK) disable iff (rst)
      (ir_valid && !dep_stall && !flush) |=> eip_out == exp_eip)
      else report_mismatch("eip_out", $sampled(eip_out), $sampled(exp_eip));

   a_eip_hold: assert property (@(posedge CLK) disable iff (rst)
      (ir_valid && dep_stall && !flush) |=> eip_out == exp_eip)
      else report_mismatch("eip_out", $sampled(eip_out), $sampled(exp_eip));

   // no new line while all four slots hold unread bytes
   a_full_no_req: assert property (@(posedge CLK) disable iff (rst)
      (held > BUF_BYTES - LINE_BYTES) |-> !icache_en)
      else report_mismatch("icache_en", $sampled(icache_en), 0);

   a_flush_drops_valid: assert property (@(posedge CLK) disable iff (rst)
      flush |=> !ir_valid)
      else report_mismatch("ir_valid", $sampled(ir_valid), 0);

   // random lengths and stalls until n instructions are taken
   task automatic run_instrs(input int n, input int stall_pct, output bit ok);
      int start;
      int cycles;
      start  = n_consumes;
      cycles = 0;
      while (n_consumes - start < n && cycles < RUN_LIMIT) begin
         @(posedge CLK);
         instr_len <= len_t'(1 + $urandom % 15);
         dep_stall <= ($urandom % 100) < stall_pct;
         cycles++;
      end
      ok = (n_consumes - start >= n);
      if (!ok) begin
         $display("Error: decoder took fewer than %0d instructions in %0d cycles", n, RUN_LIMIT);
      end
   endtask

   task automatic apply_flush();
      @(posedge CLK);
      flush <= 1'b1;
      eip   <= $urandom;
      cs    <= seg_t'($urandom);
      @(posedge CLK);
      flush <= 1'b0;
   endtask

   task automatic finish_test(input string name, input bit reached, input int err_start);
      int errs;
      errs = check_errs - err_start;
      test_num++;
      if (!reached) begin
         $display("Error: stimulus of test %0d did not reach its checks", test_num);
      end
      if (reached && errs == 0) begin
         tests_passed++;
         $display("test %0d %s: pass", test_num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: fail with %0d check errors", test_num, name, errs);
      end
   endtask

   initial begin
      bit ok;
      bit all_ok;
      int err_start;
      int mark;
      int mark2;
      int cycles;
      void'($urandom(32'hc153f21e));
      rst       <= 1'b1;
      eip       <= 32'h0000_1ff8;
      cs        <= 16'h0042;
      flush     <= 1'b0;
      dep_stall <= 1'b1;
      instr_len <= 4'd1;
      repeat (RESET_CYCLES) @(posedge CLK);
      rst <= 1'b0;

      err_start = check_errs;
      cycles = 0;
      while (n_first == 0 && cycles < 10 * T1_CYCLES) begin
         @(posedge CLK);
         cycles++;
      end
      finish_test("restart address", n_first > 0, err_start);

      err_start = check_errs;
      mark = n_reqs;
      run_instrs(40, 0, ok);
      finish_test("sequential requests", ok && (n_reqs - mark >= 4), err_start);

      err_start = check_errs;
      mark = n_windows;
      run_instrs(100, 10, ok);
      finish_test("window bytes", ok && (n_windows - mark >= 50), err_start);

      err_start = check_errs;
      mark2 = n_stall_holds;
      run_instrs(80, 50, ok);
      finish_test("eip update", ok && (n_stall_holds - mark2 > 0), err_start);

      // stop the decoder until the ring fills up
      err_start = check_errs;
      mark = n_full;
      cycles = 0;
      @(posedge CLK);
      dep_stall <= 1'b1;
      while (n_full - mark < 10 && cycles < 10 * T5_CYCLES) begin
         @(posedge CLK);
         cycles++;
      end
      run_instrs(30, 0, ok);
      finish_test("buffer full", ok && (n_full - mark >= 10), err_start);

      err_start = check_errs;
      mark   = n_flushes;
      mark2  = n_first;
      all_ok = 1'b1;
      for (int i = 0; i < 8; i++) begin
         run_instrs(3 + $urandom % 6, 20, ok);
         all_ok = all_ok && ok;
         apply_flush();
      end
      run_instrs(10, 0, ok);
      finish_test("flush restart", ok && all_ok && (n_flushes - mark == 8) &&
                  (n_first - mark2 >= 8), err_start);

      $display("tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, check_errs);
      if (tests_failed == 0 && check_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Error: run did not finish within %0d time units", WATCHDOG_TIME);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- sim.f
fetch_pkg.sv
fetch_line_if.sv
fetch_ctrl.sv
icache_req.sv
line_buffer.sv
fetch_top.sv
tb_icache_model.sv
tb_fetch.sv
